// File: logic/hawk_mem_pkg.sv
package hawk_mem_pkg;

	// bus widths
	localparam int data_w      = 256;        // one beat, half a line
	localparam int strb_w      = data_w / 8; // byte strobes per beat
	localparam int addr_w      = 64;
	localparam int id_w        = 6;
	localparam int len_w       = 8;          // awlen / arlen field
	localparam int line_offs_w = 6;          // 64 byte line

	// payload types
	typedef logic [data_w-1:0] beat_t;
	typedef logic [strb_w-1:0] strb_t;
	typedef logic [addr_w-1:0] axi_addr_t;
	typedef logic [id_w-1:0]   axi_id_t;
	typedef logic [len_w-1:0]  axi_len_t; // beats minus one, only 0 or 1 used

	// read burst engine FSM
	typedef enum logic [1:0] {
		rd_idle,  // waiting on AR
		rd_issue, // one half read per credit
		rd_drain  // waiting for credits to come home
	} rd_state_t;

endpackage

// File: logic/wr_burst_capture.sv
module wr_burst_capture import hawk_mem_pkg::*; #(
	parameter int line_depth = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// AW channel
	input  logic                          awvalid,
	output logic                          awready,
	input  axi_id_t                       awid,
	input  axi_addr_t                     awaddr,
	input  axi_len_t                      awlen,
	// W channel
	input  logic                          wvalid,
	output logic                          wready,
	input  beat_t                         wdata,
	input  strb_t                         wstrb,
	// line store write port
	output logic                          wr_en,
	output logic [$clog2(line_depth)-1:0] wr_line,
	output logic                          wr_half,
	output beat_t                         wr_data,
	output strb_t                         wr_strb,
	// completion towards the B queue
	input  logic                          full,
	output logic                          done_valid,
	output axi_id_t                       done_id
);

	localparam int line_w = $clog2(line_depth);

	logic              busy;      // address taken, data beats pending
	logic              beat;      // current beat number, also the half
	logic              last_beat; // beat number of the final beat
	axi_id_t           cur_id;
	logic [line_w-1:0] cur_line;

	// one write address at a time, none while responses are backed up
	assign awready = !busy && !full;
	assign wready  = busy;

	// beats go straight to the store on the handshake edge
	assign wr_en   = busy && wvalid;
	assign wr_line = cur_line;
	assign wr_half = beat;
	assign wr_data = wdata;
	assign wr_strb = wstrb;

	// count decides the end of burst, wlast ignored
	assign done_valid = wr_en && (beat == last_beat);
	assign done_id    = cur_id;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			beat <= 1'b0;
		end else if (awvalid && awready) begin
			busy <= 1'b1;
			beat <= 1'b0;
		end else if (wr_en) begin
			beat <= beat + 1'b1;
			if (done_valid)
				busy <= 1'b0; // awready back next cycle
		end
	end

	// address payload, captured on AW handshake
	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			cur_id    <= awid;
			cur_line  <= awaddr[line_offs_w +: line_w]; // wraps modulo line_depth
			last_beat <= (awlen != '0);
		end
	end

endmodule

// File: logic/line_store.sv
module line_store import hawk_mem_pkg::*; #(
	parameter int line_depth = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// write port, strobe merged
	input  logic                          wr_en,
	input  logic [$clog2(line_depth)-1:0] wr_line,
	input  logic                          wr_half,
	input  beat_t                         wr_data,
	input  strb_t                         wr_strb,
	// read port, one cycle latency
	input  logic                          rd_en,
	input  logic [$clog2(line_depth)-1:0] rd_line,
	input  logic                          rd_half,
	output beat_t                         rd_data
);

	beat_t           mem [2][line_depth]; // [half][line]
	logic [line_depth-1:0] written;       // line has seen a write since reset
	beat_t           merged [2];          // next contents of both halves
	logic            line_written;

	assign line_written = written[wr_line];

	// byte merge for both halves of the addressed line
	// a fresh line gets zeros wherever the strobe is off
	always_comb begin
		for (int h = 0; h < 2; h++) begin
			for (int b = 0; b < strb_w; b++) begin
				if (wr_strb[b] && (wr_half == h[0]))
					merged[h][8*b +: 8] = wr_data[8*b +: 8];
				else if (line_written)
					merged[h][8*b +: 8] = mem[h][wr_line][8*b +: 8]; // keep old byte
				else
					merged[h][8*b +: 8] = 8'h00;
			end
		end
	end

	// other half only rewritten on the first write to the line
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int h = 0; h < 2; h++) begin
				if ((wr_half == h[0]) || !line_written)
					mem[h][wr_line] <= merged[h];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			written <= '0;
		else if (wr_en)
			written[wr_line] <= 1'b1;
	end

	// read sees pre-write contents and flag on a same-edge collision
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= written[rd_line] ? mem[rd_half][rd_line] : '0; // unwritten reads zero
	end

endmodule

// File: logic/bresp_queue.sv
module bresp_queue import hawk_mem_pkg::*; #(
	parameter int bresp_depth = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       done_valid, // push, write burst finished
	input  axi_id_t    done_id,
	output logic       full,
	// B channel
	output logic       bvalid,
	input  logic       bready,
	output axi_id_t    bid,
	output logic [1:0] bresp
);

	localparam int ptr_w = (bresp_depth > 1) ? $clog2(bresp_depth) : 1;
	localparam int cnt_w = $clog2(bresp_depth + 1);

	axi_id_t          ids [bresp_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             push;
	logic             pop;

	assign push = done_valid && !full; // awready gating keeps this from dropping
	assign pop  = bvalid && bready;

	assign full   = (count == cnt_w'(bresp_depth));
	assign bvalid = (count != '0);
	assign bid    = ids[rd_ptr]; // head entry
	assign bresp  = 2'b00;       // always okay

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(bresp_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(bresp_depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + cnt_w'(push) - cnt_w'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			ids[wr_ptr] <= done_id;
	end

endmodule

// File: logic/rd_burst_engine.sv
module rd_burst_engine import hawk_mem_pkg::*; #(
	parameter int line_depth = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// AR channel
	input  logic                          arvalid,
	output logic                          arready,
	input  axi_id_t                       arid,
	input  axi_addr_t                     araddr,
	input  axi_len_t                      arlen,
	// line store read port
	output logic                          rd_en,
	output logic [$clog2(line_depth)-1:0] rd_line,
	output logic                          rd_half,
	// beat tags, aligned with rd_data
	output logic                          beat_valid,
	output axi_id_t                       beat_id,
	output logic                          beat_last,
	input  logic                          credit_return // one per beat taken on R
);

	localparam int         line_w      = $clog2(line_depth);
	localparam logic [1:0] credit_init = 2'd2; // beat buffer depth

	rd_state_t         state;
	logic [1:0]        credits;
	logic              next_half; // half to issue next
	logic              last_half;
	axi_id_t           cur_id;
	logic [line_w-1:0] cur_line;

	assign arready = (state == rd_idle);
	assign rd_en   = (state == rd_issue) && (credits != 2'd0); // never at zero credit
	assign rd_line = cur_line;
	assign rd_half = next_half;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= rd_idle;
			credits    <= credit_init;
			next_half  <= 1'b0;
			beat_valid <= 1'b0;
			beat_last  <= 1'b0;
		end else begin
			credits    <= credits - 2'(rd_en) + 2'(credit_return);
			beat_valid <= rd_en; // store answers next cycle
			beat_last  <= rd_en && (next_half == last_half);
			case (state)
				rd_idle: begin
					if (arvalid && arready) begin
						state     <= rd_issue;
						next_half <= 1'b0;
					end
				end
				rd_issue: begin
					if (rd_en) begin
						next_half <= next_half + 1'b1;
						if (next_half == last_half)
							state <= rd_drain;
					end
				end
				rd_drain: begin
					// leave as the last credit lands, arready up right after
					if (credits + 2'(credit_return) == credit_init)
						state <= rd_idle;
				end
				default: state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			cur_id    <= arid;
			cur_line  <= araddr[line_offs_w +: line_w];
			last_half <= (arlen != '0); // one or two beats
		end
		beat_id <= cur_id;
	end

endmodule

// File: logic/rd_beat_buffer.sv
module rd_beat_buffer import hawk_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// beats from the store, no ready, credits guard the depth
	input  logic       beat_valid,
	input  axi_id_t    beat_id,
	input  logic       beat_last,
	input  beat_t      rd_data,
	// R channel
	output logic       rvalid,
	input  logic       rready,
	output axi_id_t    rid,
	output beat_t      rdata,
	output logic [1:0] rresp,
	output logic       rlast,
	output logic       credit_return
);

	beat_t      data_q [2];
	axi_id_t    id_q [2];
	logic [1:0] last_q;
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       empty;
	logic       push;
	logic       pop;

	assign empty = (count == 2'd0);

	// fall-through when empty, so the store output goes out directly
	assign rvalid = !empty || beat_valid;
	assign rdata  = empty ? rd_data : data_q[rd_ptr];
	assign rid    = empty ? beat_id : id_q[rd_ptr];
	assign rlast  = empty ? beat_last : last_q[rd_ptr];
	assign rresp  = 2'b00;

	assign push          = beat_valid && !(empty && rready); // bypassed beats skip storage
	assign pop           = !empty && rready;
	assign credit_return = rvalid && rready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			wr_ptr <= wr_ptr + push;
			rd_ptr <= rd_ptr + pop;
			count  <= count + 2'(push) - 2'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			data_q[wr_ptr] <= rd_data;
			id_q[wr_ptr]   <= beat_id;
			last_q[wr_ptr] <= beat_last;
		end
	end

endmodule

// File: logic/hawk_mem_top.sv
module hawk_mem_top import hawk_mem_pkg::*; #(
	parameter int line_depth  = 64,
	parameter int bresp_depth = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	// AW
	input  logic       awvalid,
	output logic       awready,
	input  axi_id_t    awid,
	input  axi_addr_t  awaddr,
	input  axi_len_t   awlen,
	// W
	input  logic       wvalid,
	output logic       wready,
	input  beat_t      wdata,
	input  strb_t      wstrb,
	input  logic       wlast,   // burst end comes from awlen
	// B
	output logic       bvalid,
	input  logic       bready,
	output axi_id_t    bid,
	output logic [1:0] bresp,
	// AR
	input  logic       arvalid,
	output logic       arready,
	input  axi_id_t    arid,
	input  axi_addr_t  araddr,
	input  axi_len_t   arlen,
	// R
	output logic       rvalid,
	input  logic       rready,
	output axi_id_t    rid,
	output beat_t      rdata,
	output logic [1:0] rresp,
	output logic       rlast
);

	localparam int line_w = $clog2(line_depth);

	// write side
	logic              wr_en, wr_half;
	logic [line_w-1:0] wr_line;
	beat_t             wr_data;
	strb_t             wr_strb;
	logic              done_valid, full;
	axi_id_t           done_id;
	// read side
	logic              rd_en, rd_half;
	logic [line_w-1:0] rd_line;
	beat_t             rd_data;
	logic              beat_valid, beat_last, credit_return;
	axi_id_t           beat_id;

	wr_burst_capture #(.line_depth(line_depth)) u_wr_capture (
		.clk, .rst_n,
		.awvalid, .awready, .awid, .awaddr, .awlen,
		.wvalid, .wready, .wdata, .wstrb,
		.wr_en, .wr_line, .wr_half, .wr_data, .wr_strb,
		.full, .done_valid, .done_id
	);

	line_store #(.line_depth(line_depth)) u_line_store (
		.clk, .rst_n,
		.wr_en, .wr_line, .wr_half, .wr_data, .wr_strb,
		.rd_en, .rd_line, .rd_half, .rd_data
	);

	bresp_queue #(.bresp_depth(bresp_depth)) u_bresp_queue (
		.clk, .rst_n,
		.done_valid, .done_id, .full,
		.bvalid, .bready, .bid, .bresp
	);

	rd_burst_engine #(.line_depth(line_depth)) u_rd_engine (
		.clk, .rst_n,
		.arvalid, .arready, .arid, .araddr, .arlen,
		.rd_en, .rd_line, .rd_half,
		.beat_valid, .beat_id, .beat_last, .credit_return
	);

	rd_beat_buffer u_rd_buffer (
		.clk, .rst_n,
		.beat_valid, .beat_id, .beat_last, .rd_data,
		.rvalid, .rready, .rid, .rdata, .rresp, .rlast, .credit_return
	);

endmodule

// File: verification/hawk_mem_tb.sv
module hawk_mem_tb import hawk_mem_pkg::*; ();

	localparam int line_depth   = 64;
	localparam int bresp_depth  = 4;
	localparam int reset_cycles = 16;
	localparam int cycle_limit  = reset_cycles + 6 * 200; // six tests, 200 cycles each

	logic clk = 1'b0;
	logic rst_n;
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	logic arvalid, arready, rvalid, rready, rlast;
	axi_id_t awid, bid, arid, rid;
	axi_addr_t awaddr, araddr;
	axi_len_t awlen, arlen;
	beat_t wdata, rdata;
	strb_t wstrb;
	logic [1:0] bresp, rresp;

	integer  seed = 32'hdbd4;
	int      errors = 0;
	int      test_base = 0; // error count when the current test began
	int      tests_passed = 0;
	int      tests_failed = 0;
	int      cycles = 0;
	logic    hold_b;        // keeps bready low
	axi_id_t exp_bid [$];   // responses still owed in write order
	beat_t   shadow [2][line_depth]; // expected contents where unwritten bytes read zero

	always #2 clk = ~clk;

	hawk_mem_top #(.line_depth(line_depth), .bresp_depth(bresp_depth)) dut0 (.*);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, run stopped", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic log_mismatch(string name, logic [data_w-1:0] exp_v,
			logic [data_w-1:0] act_v);
		errors++;
		$display("Fail t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
	endtask

	task automatic report_error(string what);
		errors++;
		$display("Error t=%0t %s", $time, what);
	endtask

	// payload hold on B and R while stalled
	assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bid))
		else report_error("bvalid or bid changed before bready");
	assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
		else report_error("R channel changed while rready was low");
	// data phase opens the cycle after the address
	assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && awready |=> wready && !awready)
		else report_error("wready not up or awready not down after the AW handshake");

	always @(posedge clk) bready <= !hold_b && (($random(seed) & 3) != 0); // 1 in 4 stalls

	// responses checked in write order
	always @(negedge clk) begin : b_check
		axi_id_t want;
		if (rst_n && bvalid && bready) begin
			assert (exp_bid.size() != 0)
				else report_error("write response with no write outstanding");
			if (exp_bid.size() != 0) begin
				want = exp_bid.pop_front();
				assert (bid === want) else log_mismatch("bid", want, bid);
			end
			assert (bresp === 2'b00) else log_mismatch("bresp", '0, bresp);
		end
	end

	function automatic beat_t rand_beat();
		beat_t b;
		for (int i = 0; i < data_w / 32; i++)
			b[32*i +: 32] = $random(seed);
		return b;
	endfunction

	// every task starts and ends on a rising edge
	task automatic write_burst(axi_id_t id, axi_addr_t addr, axi_len_t len, strb_t s0, strb_t s1);
		beat_t d;
		strb_t s;
		int    line;
		line = addr[line_offs_w +: $clog2(line_depth)]; // modulo line_depth
		awvalid <= 1'b1;
		awid    <= id;
		awaddr  <= addr;
		awlen   <= len;
		do @(negedge clk); while (!awready);
		@(posedge clk); // AW handshake edge
		awvalid <= 1'b0;
		for (int h = 0; h <= int'(len); h++) begin
			d = rand_beat();
			s = (h == 0) ? s0 : s1;
			wvalid <= 1'b1;
			wdata  <= d;
			wstrb  <= s;
			wlast  <= (h == int'(len));
			do @(negedge clk); while (!wready);
			for (int b = 0; b < strb_w; b++)
				if (s[b])
					shadow[h][line][8*b +: 8] = d[8*b +: 8]; // strobed bytes only
			if (h == int'(len))
				exp_bid.push_back(id);
			@(posedge clk);
		end
		wvalid <= 1'b0;
		wlast  <= 1'b0;
	endtask

	task automatic read_burst(axi_id_t id, axi_addr_t addr, axi_len_t len, bit stall);
		int line;
		int h;
		int gap;
		line = addr[line_offs_w +: $clog2(line_depth)];
		h    = 0;
		gap  = 0;
		arvalid <= 1'b1;
		arid    <= id;
		araddr  <= addr;
		arlen   <= len;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		while (h <= int'(len)) begin
			rready <= stall ? (($random(seed) & 1) != 0) : 1'b1;
			@(negedge clk);
			if (rvalid && rready) begin
				assert (stall || h != 0 || gap == 1)
					else report_error("first read beat not 2 cycles after the AR handshake");
				assert (rdata === shadow[h][line])
					else log_mismatch("rdata", shadow[h][line], rdata);
				assert (rid === id) else log_mismatch("rid", id, rid);
				assert (rlast === (h == int'(len)))
					else log_mismatch("rlast", (h == int'(len)), rlast);
				assert (rresp === 2'b00) else log_mismatch("rresp", '0, rresp);
				h++;
			end else if (h == 0) begin
				gap++;
			end
			@(posedge clk);
		end
		rready <= 1'b0;
		@(negedge clk); // arready back and R quiet
		assert (arready) else report_error("arready did not return after the final read beat");
		assert (!rvalid) else report_error("extra read beat after rlast");
		@(posedge clk);
	endtask

	task automatic drain_b();
		while (exp_bid.size() != 0)
			@(posedge clk);
	endtask

	task automatic clear_shadow();
		for (int i = 0; i < line_depth; i++) begin
			shadow[0][i] = '0;
			shadow[1][i] = '0;
		end
	endtask

	task automatic finish_test(string name);
		if (errors == test_base) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_base);
		end
		test_base = errors;
	endtask

	initial begin
		rst_n   = 1'b0;
		hold_b  = 1'b1;
		awvalid = 1'b0;
		awid    = '0;
		awaddr  = '0;
		awlen   = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wlast   = 1'b0;
		bready  = 1'b0;
		arvalid = 1'b0;
		arid    = '0;
		araddr  = '0;
		arlen   = '0;
		rready  = 1'b0;
		clear_shadow();
		repeat (reset_cycles) @(posedge clk);
		rst_n  <= 1'b1;
		hold_b <= 1'b0;
		@(posedge clk);

		write_burst(6'h01, 64'd3 << 6, 8'd1, '1, '1);
		drain_b();
		read_burst(6'h11, 64'd3 << 6, 8'd1, 1'b0);
		finish_test("full-line round trip");

		write_burst(6'h02, 64'd5 << 6, 8'd1, '1, '1);
		write_burst(6'h03, 64'd5 << 6, 8'd1, 32'h0f0f_00ff, 32'hf000_000f); // over old data
		write_burst(6'h04, 64'd9 << 6, 8'd1, 32'h0000_ff00, 32'h8000_0001); // fresh line
		drain_b();
		read_burst(6'h12, 64'd5 << 6, 8'd1, 1'b0);
		read_burst(6'h13, 64'd9 << 6, 8'd1, 1'b0);
		finish_test("strobe merge");

		read_burst(6'h21, 64'h0000_0100_0000_0000 | (64'd12 << 6), 8'd1, 1'b0); // aliases line 12
		finish_test("unwritten line");

		hold_b <= 1'b1;
		for (int i = 0; i < bresp_depth; i++)
			write_burst(6'h30 + i, (64'd20 + i) << 6, 8'd0, '1, '0);
		repeat (4) begin
			@(negedge clk);
			assert (!awready) else report_error("awready high while the response queue is full");
		end
		@(posedge clk);
		fork
			write_burst(6'h34, 64'd24 << 6, 8'd0, '1, '0); // waits for a free slot
			begin
				repeat (3) @(posedge clk);
				hold_b <= 1'b0;
			end
		join
		drain_b();
		finish_test("write response");

		write_burst(6'h05, 64'd30 << 6, 8'd1, '1, '1);
		write_burst(6'h06, 64'd31 << 6, 8'd1, 32'h5555_aaaa, '1);
		drain_b();
		for (int i = 0; i < 4; i++)
			read_burst(6'h20 + i, (64'd30 + (i & 1)) << 6, 8'd1, 1'b1);
		hold_b <= 1'b1; // leave a response pending across reset
		write_burst(6'h07, 64'd32 << 6, 8'd0, '1, '0);
		repeat (2) @(posedge clk);
		rst_n <= 1'b0;
		repeat (reset_cycles) @(posedge clk);
		exp_bid.delete();
		clear_shadow(); // written flags cleared by reset
		rst_n  <= 1'b1;
		hold_b <= 1'b0;
		@(negedge clk);
		assert (!rvalid && !bvalid) else report_error("rvalid or bvalid high after reset");
		assert (awready && arready && !wready) else report_error("ready signals wrong after reset");
		@(posedge clk);
		read_burst(6'h28, 64'd30 << 6, 8'd1, 1'b1);
		finish_test("read back-pressure");

		write_burst(6'h09, (64'd40 << 6) | 64'h20, 8'd0, 32'h00ff_ff00, '0);
		drain_b();
		read_burst(6'h19, (64'd40 << 6) | 64'h20, 8'd0, 1'b0);
		read_burst(6'h1a, 64'd40 << 6, 8'd1, 1'b0); // other half stays zero
		finish_test("single-beat burst");

		$display("tests passed %0d failed %0d, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: hawk_mem.f
logic/hawk_mem_pkg.sv
logic/wr_burst_capture.sv
logic/line_store.sv
logic/bresp_queue.sv
logic/rd_burst_engine.sv
logic/rd_beat_buffer.sv
logic/hawk_mem_top.sv
verification/hawk_mem_tb.sv

// File: Bender.yml
package:
  name: hawk_mem

sources:
  # package first, then leaf modules, then the top level
  - logic/hawk_mem_pkg.sv
  - logic/wr_burst_capture.sv
  - logic/line_store.sv
  - logic/bresp_queue.sv
  - logic/rd_burst_engine.sv
  - logic/rd_beat_buffer.sv
  - logic/hawk_mem_top.sv
  - target: test
    files:
      - verification/hawk_mem_tb.sv
